/* Makefile */
# Verilator simulation of the board I/O block

VERILATOR ?= verilator
TOP ?= devBoardIoTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* buttons/buttonDebouncer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button debouncer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module buttonDebouncer
(
	input wire clock,
	input wire arstN,
	input wire sampleTick,
	input wire button,
	output logic level,
	output logic pressPulse
);
	localparam int COUNT_W = $clog2(`DEBOUNCE_COUNT);
	localparam logic [COUNT_W-1:0] LAST_SAMPLE = COUNT_W'(`DEBOUNCE_COUNT - 1);

	logic [1:0] syncChain;
	logic [COUNT_W-1:0] stableCount;
	logic flip;

	// Last of the required run of differing samples
	assign flip = sampleTick && (syncChain[1] != level) && (stableCount == LAST_SAMPLE);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			syncChain <= '0;
			stableCount <= '0;
			level <= 1'b0;
			pressPulse <= 1'b0;
		end
		else
		begin
			// Two flops against metastability
			syncChain <= {syncChain[0], button};
			if (sampleTick)
			begin
				// A sample matching the level breaks the run
				if (flip || (syncChain[1] == level))
					stableCount <= '0;
				else
					stableCount <= stableCount + 1'b1;
			end
			if (flip)
				level <= ~level;
			// Pulses for one cycle with the rising level
			pressPulse <= flip && !level;
		end
	end

	levelOnSample: assert property (@(posedge clock) disable iff (!arstN)
		$changed(level) |-> $past(sampleTick));

endmodule

`default_nettype wire

/* common/boardIoPkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "boardIo_defs.svh"

package boardIoPkg;

	// Word index into the register map, taken from PADDR[4:2]
	typedef enum logic [2:0]
	{
		LED_REG     = 3'd0,
		BUTTON_REG  = 3'd1,
		PRESS_REG   = 3'd2,
		DISPLAY_REG = 3'd3,
		MODE_REG    = 3'd4
	} regAddrT;

	// Hex view, nibble 3 lands on the leftmost digit
	typedef struct packed
	{
		logic [15:0] reserved;
		logic [`DIGIT_COUNT-1:0][3:0] nibble;
	} hexViewT;

	// Raw view, one segment byte per digit
	typedef struct packed
	{
		logic [`DIGIT_COUNT-1:0][7:0] pattern;
	} rawViewT;

	// Same display word, read either way depending on mode
	typedef union packed
	{
		hexViewT hex;
		rawViewT raw;
	} displayWordT;

endpackage

`default_nettype wire

/* common/boardIo_defs.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O sizes and dividers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BOARD_IO_DEFS_SVH
`define BOARD_IO_DEFS_SVH

// Push buttons on the board
`define BUTTON_COUNT 4

// Digits on the multiplexed display
`define DIGIT_COUNT 4

// Clock cycles between digit scan ticks
`define SCAN_DIV 16

// Clock cycles between debounce sample ticks
`define DEBOUNCE_DIV 8

// Equal samples needed to flip a debounced level
`define DEBOUNCE_COUNT 4

`endif

/* common/displayIf.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface displayIf import boardIoPkg::*; ();

	// Word and mode from the register file
	displayWordT displayWord;
	logic rawMode;
	// High until software first writes the display word
	logic blank;
	// Digit advance enable from the timer
	logic scanTick;

	modport regs (output displayWord, output rawMode, output blank);

	modport scanner (input displayWord, input rawMode, input blank, input scanTick);

	modport timer (output scanTick);

endinterface

`default_nettype wire

/* display/sevenSegScanner.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Seven-segment scanner
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module sevenSegScanner
(
	input wire clock,
	input wire arstN,
	displayIf.scanner display,
	output logic [7:0] segment,
	output logic [`DIGIT_COUNT-1:0] digit
);
	logic [`DIGIT_COUNT-1:0] nextDigit;
	logic [3:0] nibble;
	logic [7:0] rawByte;
	logic [6:0] hexSegments;
	logic [7:0] nextSegment;

	// Rotate toward higher digits on each scan tick
	assign nextDigit = display.scanTick ? {digit[`DIGIT_COUNT-2:0], digit[`DIGIT_COUNT-1]} : digit;

	// Digit k shows nibble or byte from the top down
	always_comb
	begin
		nibble = '0;
		rawByte = '0;
		for (int k = 0; k < `DIGIT_COUNT; k++)
		begin
			if (nextDigit[k])
			begin
				nibble = display.displayWord.hex.nibble[`DIGIT_COUNT-1-k];
				rawByte = display.displayWord.raw.pattern[`DIGIT_COUNT-1-k];
			end
		end
	end

	// Hex glyphs, bit 0 = a up to bit 6 = g
	always_comb
	begin
		case (nibble)
			4'h0: hexSegments = 7'h3f;
			4'h1: hexSegments = 7'h06;
			4'h2: hexSegments = 7'h5b;
			4'h3: hexSegments = 7'h4f;
			4'h4: hexSegments = 7'h66;
			4'h5: hexSegments = 7'h6d;
			4'h6: hexSegments = 7'h7d;
			4'h7: hexSegments = 7'h07;
			4'h8: hexSegments = 7'h7f;
			4'h9: hexSegments = 7'h6f;
			4'ha: hexSegments = 7'h77;
			4'hb: hexSegments = 7'h7c;
			4'hc: hexSegments = 7'h39;
			4'hd: hexSegments = 7'h5e;
			4'he: hexSegments = 7'h79;
			default: hexSegments = 7'h71;
		endcase
	end

	// Blank wins, dp stays dark in hex mode
	assign nextSegment = display.blank ? 8'h00 :
		(display.rawMode ? rawByte : {1'b0, hexSegments});

	// Select and pattern move in the same edge
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			digit <= `DIGIT_COUNT'(1);
			segment <= '0;
		end
		else
		begin
			digit <= nextDigit;
			segment <= nextSegment;
		end
	end

	digitOneHot: assert property (@(posedge clock) disable iff (!arstN)
		$onehot(digit));

endmodule

`default_nettype wire

/* hdl/apbRegisterFile.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module apbRegisterFile import boardIoPkg::*;
(
	input wire clock,
	input wire arstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [4:0] paddr,
	input wire [31:0] pwdata,
	input wire [`BUTTON_COUNT-1:0] levels,
	input wire [`BUTTON_COUNT-1:0] pressPulses,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic [3:0] led,
	displayIf.regs display
);
	regAddrT index;
	logic access;
	logic writeEn;
	logic addrError;
	logic [31:0] readWord;
	logic [`BUTTON_COUNT-1:0] pressReg;
	logic [`BUTTON_COUNT-1:0] pressClear;
	displayWordT displayReg;
	logic modeReg;
	logic blankReg;

	// Word index, byte lanes ignored
	assign index = regAddrT'(paddr[4:2]);
	// Zero wait states, access cycle completes the transfer
	assign access = psel && penable;
	assign writeEn = access && pwrite && !addrError;

	// Read mux and error decode
	always_comb
	begin
		readWord = '0;
		addrError = 1'b0;
		case (index)
			LED_REG: readWord = 32'(led);
			BUTTON_REG:
			begin
				readWord = 32'(levels);
				// Button levels are read only
				addrError = pwrite;
			end
			PRESS_REG: readWord = 32'(pressReg);
			DISPLAY_REG: readWord = displayReg;
			MODE_REG: readWord = 32'(modeReg);
			default: addrError = 1'b1;
		endcase
	end

	assign prdata = (access && !pwrite && !addrError) ? readWord : '0;
	assign pslverr = access && addrError;

	// Write 1 to clear
	assign pressClear = (writeEn && index == PRESS_REG) ? pwdata[`BUTTON_COUNT-1:0] : '0;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			led <= '0;
			pressReg <= '0;
			displayReg <= '0;
			modeReg <= 1'b0;
			blankReg <= 1'b1;
		end
		else
		begin
			if (writeEn)
			begin
				case (index)
					LED_REG: led <= pwdata[3:0];
					DISPLAY_REG:
					begin
						displayReg <= pwdata;
						blankReg <= 1'b0;
					end
					MODE_REG: modeReg <= pwdata[0];
					default: ;
				endcase
			end
			// New press beats a clear in the same cycle
			pressReg <= (pressReg & ~pressClear) | pressPulses;
		end
	end

	assign display.displayWord = displayReg;
	assign display.rawMode = modeReg;
	assign display.blank = blankReg;

	// Access phase must follow a setup phase
	apbSetupFirst: assert property (@(posedge clock) disable iff (!arstN)
		penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

/* hdl/devBoardIo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Devboard I/O top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module devBoardIo
(
	input wire clock,
	input wire arstN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [4:0] paddr,
	input wire [31:0] pwdata,
	input wire [`BUTTON_COUNT-1:0] notButton,
	output logic [31:0] prdata,
	output logic pslverr,
	output logic [3:0] notLed,
	output logic [7:0] notSegment,
	output logic [`DIGIT_COUNT-1:0] notDigit
);
	// Board pins are active low, core logic active high
	logic [`BUTTON_COUNT-1:0] button;
	logic [`BUTTON_COUNT-1:0] levels;
	logic [`BUTTON_COUNT-1:0] pressPulses;
	logic [3:0] led;
	logic [7:0] segment;
	logic [`DIGIT_COUNT-1:0] digit;
	logic sampleTick;

	displayIf displayBus ();

	assign button = ~notButton;
	assign notLed = ~led;
	assign notSegment = ~segment;
	assign notDigit = ~digit;

	scanTimer scanTimer_inst (.clock, .arstN, .sampleTick, .ticks(displayBus.timer));

	// One debouncer per button, shared sample tick
	for (genvar i = 0; i < `BUTTON_COUNT; i++)
	begin : gDebounce
		buttonDebouncer buttonDebouncer_inst (.clock, .arstN, .sampleTick,
			.button(button[i]), .level(levels[i]), .pressPulse(pressPulses[i]));
	end

	apbRegisterFile apbRegisterFile_inst (.clock, .arstN, .psel, .penable, .pwrite,
		.paddr, .pwdata, .levels, .pressPulses, .prdata, .pslverr, .led,
		.display(displayBus.regs));

	sevenSegScanner sevenSegScanner_inst (.clock, .arstN, .display(displayBus.scanner),
		.segment, .digit);

endmodule

`default_nettype wire

/* hdl/scanTimer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample and scan tick generator
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module scanTimer
(
	input wire clock,
	input wire arstN,
	output logic sampleTick,
	displayIf.timer ticks
);
	localparam int SAMPLE_W = $clog2(`DEBOUNCE_DIV);
	localparam int SCAN_W = $clog2(`SCAN_DIV);
	localparam logic [SAMPLE_W-1:0] SAMPLE_LOAD = SAMPLE_W'(`DEBOUNCE_DIV - 1);
	localparam logic [SCAN_W-1:0] SCAN_LOAD = SCAN_W'(`SCAN_DIV - 1);

	logic [SAMPLE_W-1:0] sampleCount;
	logic [SCAN_W-1:0] scanCount;

	// Both counters reload at zero, ticks registered so they start low
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			sampleCount <= SAMPLE_LOAD;
			scanCount <= SCAN_LOAD;
			sampleTick <= 1'b0;
			ticks.scanTick <= 1'b0;
		end
		else
		begin
			// Debounce sample period
			sampleTick <= (sampleCount == '0);
			sampleCount <= (sampleCount == '0) ? SAMPLE_LOAD : sampleCount - 1'b1;
			// Digit scan period
			ticks.scanTick <= (scanCount == '0);
			scanCount <= (scanCount == '0) ? SCAN_LOAD : scanCount - 1'b1;
		end
	end

	// Enables are single pulses, never back to back
	sampleTickSingle: assert property (@(posedge clock) disable iff (!arstN)
		sampleTick |=> !sampleTick);
	scanTickSingle: assert property (@(posedge clock) disable iff (!arstN)
		ticks.scanTick |=> !ticks.scanTick);

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/boardIoPkg.sv
common/displayIf.sv
hdl/scanTimer.sv
buttons/buttonDebouncer.sv
display/sevenSegScanner.sv
hdl/apbRegisterFile.sv
hdl/devBoardIo.sv
verif/devBoardIoTb.sv

/* verif/devBoardIoTb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "boardIo_defs.svh"

module devBoardIoTb import boardIoPkg::*; ();
	localparam int XFER = 3;
	localparam int BOUND = 2 + `DEBOUNCE_DIV * (`DEBOUNCE_COUNT + 1);
	localparam int SWEEP = 2 * `DIGIT_COUNT * `SCAN_DIV;
	// Sum of the per-test cycle budgets
	localparam int BUDGET = (16 * XFER + 8) + (11 * XFER + 8) + (3 * BOUND + 4 * XFER + 16)
		+ (BOUND * 2 + 7 * XFER + 8) + (SWEEP * 3 / 2 + 3 * XFER + 8) + (SWEEP + 2 * XFER + 8);
	// Hex glyphs with segment a in bit 0
	localparam logic [6:0] GLYPH [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic clock;
	logic arstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [4:0] paddr;
	logic [31:0] pwdata;
	logic [3:0] notButton;
	logic [31:0] prdata;
	logic pslverr;
	logic [3:0] notLed;
	logic [7:0] notSegment;
	logic [3:0] notDigit;
	// Expected register state
	logic [3:0] expLed;
	logic [3:0] expButtons;
	logic [3:0] expPress;
	logic [31:0] expDisplay;
	logic expMode;
	logic expBlank;
	// Display state one cycle back to line up with the registered outputs
	logic [31:0] lastDisplay;
	logic lastMode;
	logic lastBlank;
	logic [3:0] prevDigit;
	logic [31:0] expRead;
	logic expErr;
	logic [7:0] expSegment;
	int shownDigit;
	logic [31:0] lfsr;
	logic [3:0] visited;
	string testName;
	int errorCount;
	int errorsAtStart;
	int testsPassed;
	int testsFailed;

	devBoardIo devBoardIo_inst (.clock, .arstN, .psel, .penable, .pwrite, .paddr, .pwdata,
		.notButton, .prdata, .pslverr, .notLed, .notSegment, .notDigit);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Watchdog at twice the summed budgets
	initial
	begin
		repeat (2 * BUDGET + 8) @(posedge clock);
		$display("Timeout: run did not end within %0d cycles", 2 * BUDGET + 8);
		$display("*** FAILED ***");
		$finish;
	end

	// Read data and error flag implied by the register map
	always_comb
	begin
		expErr = (paddr[4:2] > 3'd4) || (pwrite && paddr[4:2] == BUTTON_REG);
		case (paddr[4:2])
			LED_REG: expRead = {28'b0, expLed};
			BUTTON_REG: expRead = {28'b0, expButtons};
			PRESS_REG: expRead = {28'b0, expPress};
			DISPLAY_REG: expRead = expDisplay;
			MODE_REG: expRead = {31'b0, expMode};
			default: expRead = '0;
		endcase
		// Erroring accesses return zero data
		if (expErr)
			expRead = '0;
	end

	always @(posedge clock)
	begin
		lastDisplay <= expDisplay;
		lastMode <= expMode;
		lastBlank <= expBlank;
		prevDigit <= notDigit;
	end

	// Digit k shows nibble or byte 3-k
	always_comb
	begin
		shownDigit = 0;
		for (int k = 0; k < `DIGIT_COUNT; k++)
		begin
			if (!notDigit[k])
				shownDigit = k;
		end
		if (lastBlank)
			expSegment = 8'h00;
		else if (lastMode)
			expSegment = lastDisplay[8 * (`DIGIT_COUNT - 1 - shownDigit) +: 8];
		else
			expSegment = {1'b0, GLYPH[lastDisplay[4 * (`DIGIT_COUNT - 1 - shownDigit) +: 4]]};
	end

	readCheck: assert property (@(posedge clock) disable iff (!arstN)
		psel && penable && (!pwrite || expErr) |-> prdata == expRead)
	else
	begin
		$display("ERROR %s: read at %h expected %h actual %h", testName,
			$sampled(paddr), $sampled(expRead), $sampled(prdata));
		errorCount++;
	end

	errorFlagCheck: assert property (@(posedge clock) disable iff (!arstN)
		psel && penable |-> pslverr == expErr)
	else
	begin
		$display("ERROR %s: pslverr at %h expected %b actual %b", testName,
			$sampled(paddr), $sampled(expErr), $sampled(pslverr));
		errorCount++;
	end

	ledCheck: assert property (@(posedge clock) disable iff (!arstN) notLed == ~expLed)
	else
	begin
		$display("ERROR %s: notLed expected %h actual %h", testName,
			~$sampled(expLed), $sampled(notLed));
		errorCount++;
	end

	segmentCheck: assert property (@(posedge clock) disable iff (!arstN)
		notSegment == ~expSegment)
	else
	begin
		$display("ERROR %s: notSegment on digit %0d expected %h actual %h", testName,
			$sampled(shownDigit), ~$sampled(expSegment), $sampled(notSegment));
		errorCount++;
	end

	digitOneHotCheck: assert property (@(posedge clock) disable iff (!arstN)
		$onehot(~notDigit))
	else
	begin
		$display("Test %s: digit select is not one-hot (%b)", testName, $sampled(notDigit));
		errorCount++;
	end

	// Select only ever steps to the next digit
	digitRotateCheck: assert property (@(posedge clock) disable iff (!arstN)
		notDigit != prevDigit |-> notDigit == {prevDigit[2:0], prevDigit[3]})
	else
	begin
		$display("Test %s: digit select jumped from %b to %b", testName,
			$sampled(prevDigit), $sampled(notDigit));
		errorCount++;
	end

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	task automatic waitCycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	// Setup cycle then access cycle then idle
	task automatic driveTransfer(input logic write, input logic [2:0] index,
		input logic [31:0] data);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= {index, 2'b00};
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apbWrite(input logic [2:0] index, input logic [31:0] data);
		driveTransfer(1'b1, index, data);
		// Register takes the value at the end of the access cycle
		case (index)
			LED_REG: expLed <= data[3:0];
			PRESS_REG: expPress <= expPress & ~data[3:0];
			DISPLAY_REG:
			begin
				expDisplay <= data;
				expBlank <= 1'b0;
			end
			MODE_REG: expMode <= data[0];
			default: ;
		endcase
	endtask

	task automatic apbRead(input logic [2:0] index);
		driveTransfer(1'b0, index, 32'h0);
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
	endtask

	task automatic finishTest();
		@(negedge clock);
		if (errorCount == errorsAtStart)
		begin
			testsPassed++;
			$display("Test %s: ok", testName);
		end
		else
		begin
			testsFailed++;
			$display("Test %s: %0d errors", testName, errorCount - errorsAtStart);
		end
		@(posedge clock);
	endtask

	initial
	begin
		arstN <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		notButton <= '1;
		expLed <= '0;
		expButtons <= '0;
		expPress <= '0;
		expDisplay <= '0;
		expMode <= 1'b0;
		expBlank <= 1'b1;
		lfsr = 32'h6f7e_d87f;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		testName = "reset";
		repeat (2) @(posedge clock);
		arstN <= 1'b1;

		startTest("ledRegister");
		repeat (8)
		begin
			apbWrite(LED_REG, takeBits(4));
			apbRead(LED_REG);
		end
		finishTest();

		startTest("busErrors");
		for (int index = 5; index < 8; index++)
		begin
			apbWrite(3'(index), takeBits(32));
			apbRead(3'(index));
		end
		apbWrite(BUTTON_REG, takeBits(32));
		apbRead(LED_REG);
		apbRead(PRESS_REG);
		apbRead(DISPLAY_REG);
		apbRead(MODE_REG);
		finishTest();

		startTest("debounce");
		// Glitch shorter than one sample period
		notButton[2] <= 1'b0;
		waitCycles(`DEBOUNCE_DIV - 3);
		notButton[2] <= 1'b1;
		waitCycles(BOUND);
		apbRead(BUTTON_REG);
		apbRead(PRESS_REG);
		notButton[2] <= 1'b0;
		waitCycles(BOUND);
		expButtons <= 4'b0100;
		expPress <= 4'b0100;
		apbRead(BUTTON_REG);
		apbRead(PRESS_REG);
		notButton[2] <= 1'b1;
		waitCycles(BOUND);
		expButtons <= '0;
		apbRead(BUTTON_REG);
		finishTest();

		startTest("pressEvents");
		notButton[1:0] <= 2'b00;
		waitCycles(BOUND + 1);
		expButtons <= 4'b0011;
		expPress <= 4'b0111;
		apbRead(PRESS_REG);
		apbRead(BUTTON_REG);
		apbWrite(PRESS_REG, 32'h1);
		apbRead(PRESS_REG);
		// Zero bits leave set events alone
		apbWrite(PRESS_REG, 32'h0);
		apbRead(PRESS_REG);
		notButton[1:0] <= 2'b11;
		waitCycles(BOUND);
		expButtons <= '0;
		apbRead(BUTTON_REG);
		finishTest();

		startTest("hexDisplay");
		apbWrite(MODE_REG, 32'h0);
		// Still blank here
		waitCycles(SWEEP / 2);
		apbWrite(DISPLAY_REG, takeBits(32));
		apbRead(DISPLAY_REG);
		waitCycles(SWEEP);
		finishTest();

		startTest("rawDisplay");
		apbWrite(MODE_REG, 32'h1);
		apbWrite(DISPLAY_REG, takeBits(32));
		visited = '0;
		repeat (SWEEP)
		begin
			@(negedge clock);
			visited = visited | ~notDigit;
		end
		visitAllDigits: assert (visited == 4'hf)
		else
		begin
			$display("Test %s: digit select did not reach every position", testName);
			errorCount++;
		end
		finishTest();

		$display("Tests passed: %0d, failed: %0d, check errors: %0d", testsPassed,
			testsFailed, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
